// ==== src/clk_ctrl_pkg.sv ====
// Speed and CPU state enums, turbo masks, divider width and speed-to-mask function
package clk_ctrl_pkg;

	// ==============================
	// Divider
	// ==============================
	localparam int DIV_WIDTH = 6;

	// Applied to the low five counter bits, CPU period is mask+1
	typedef logic [4:0] turbo_mask_t;

	localparam turbo_mask_t TURBO_ORIG = 5'b11111; // 3.5 MHz
	localparam turbo_mask_t TURBO_7M   = 5'b01111;
	localparam turbo_mask_t TURBO_14M  = 5'b00111;
	localparam turbo_mask_t TURBO_28M  = 5'b00011;
	localparam turbo_mask_t TURBO_56M  = 5'b00001; // p/n alternate every cycle

	// ==============================
	// Speed settings
	// ==============================
	typedef enum logic [2:0] {
		SPEED_ORIG = 3'd0,
		SPEED_7M   = 3'd1,
		SPEED_14M  = 3'd2,
		SPEED_28M  = 3'd3,
		SPEED_56M  = 3'd4
	} speed_e;

	// CPU enable FSM
	typedef enum logic [1:0] {
		ST_RUN      = 2'd0,
		ST_SETTLE   = 2'd1,
		ST_WAIT_RAM = 2'd2,
		ST_PAUSED   = 2'd3
	} cpu_state_e;

	function automatic turbo_mask_t speed_to_mask(input speed_e spd);
		case (spd)
			SPEED_7M:  return TURBO_7M;
			SPEED_14M: return TURBO_14M;
			SPEED_28M: return TURBO_28M;
			SPEED_56M: return TURBO_56M;
			default:   return TURBO_ORIG; // Unused codes run at original speed
		endcase
	endfunction

endpackage

// ==== src/ce_divider.sv ====
// Free-running divider producing the 7 MHz strobes and turbo-masked CPU strobes
`timescale 1ns/1ps

module ce_divider (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  clk_ctrl_pkg::turbo_mask_t turbo,
	output logic                      ce_7mp,
	output logic                      ce_7mn,
	output logic                      cpu_p,
	output logic                      cpu_n
);
	import clk_ctrl_pkg::*;

	logic [DIV_WIDTH-1:0] counter;
	turbo_mask_t          cnt_masked;
	turbo_mask_t          half_point;

	// ==============================
	// Masked counter decode
	// ==============================
	always_comb begin
		cnt_masked = counter[4:0] & turbo;
		// Top set bit of the mask, i.e. (mask+1)/2
		half_point = turbo ^ (turbo >> 1);
	end

	// ==============================
	// Counter and strobes
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			ce_7mp  <= 1'b0;
			ce_7mn  <= 1'b0;
			cpu_p   <= 1'b0;
			cpu_n   <= 1'b0;
		end else begin
			counter <= counter + 1'b1;

			// Base 7 MHz pair, 8 cycles apart
			ce_7mp <= (counter[3:0] == 4'd0);
			ce_7mn <= (counter[3:0] == 4'd8);

			cpu_p <= (cnt_masked == '0);        // Start of CPU period
			cpu_n <= (cnt_masked == half_point); // Half a period later
		end
	end

endmodule

// ==== src/speed_request.sv ====
// Speed key and pause key handling with fast tape override of the requested mask
`timescale 1ns/1ps

module speed_request (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [4:0]                speed_key, // F4..F8, one per speed
	input  logic                      pause_key,
	input  logic                      mod_active,
	input  logic                      tape_active,
	input  logic                      fast_tape_en,
	output clk_ctrl_pkg::speed_e      speed,
	output logic                      paused,
	output clk_ctrl_pkg::turbo_mask_t turbo_req
);
	import clk_ctrl_pkg::*;

	logic [4:0] key_prev;
	logic [4:0] key_rise;
	logic       pause_prev;
	logic       pause_rise;
	logic       key_hit;
	speed_e     key_speed;
	logic       fast_tape;

	// ==============================
	// Edge detect
	// ==============================
	always_comb begin
		key_rise   = speed_key & ~key_prev;
		pause_rise = pause_key & ~pause_prev;
	end

	// Highest rising key wins
	always_comb begin
		key_hit   = 1'b0;
		key_speed = SPEED_ORIG;
		for (int i = 0; i < 5; i++) begin
			if (key_rise[i]) begin
				key_hit   = 1'b1;
				key_speed = speed_e'(i);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			key_prev   <= '0;
			pause_prev <= 1'b0;
		end else begin
			key_prev   <= speed_key;
			pause_prev <= pause_key;
		end
	end

	// ==============================
	// Speed setting and pause flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			speed  <= SPEED_ORIG;
			paused <= 1'b0;
		end else begin
			if (key_hit && !mod_active) begin // Modifier held means another function
				speed <= key_speed;
			end

			if (pause_rise) paused <= ~paused;
		end
	end

	// Tape loading runs flat out when fast load is on
	assign fast_tape = tape_active & fast_tape_en;

	always_comb begin
		if (fast_tape) begin
			turbo_req = TURBO_56M;
		end else begin
			turbo_req = speed_to_mask(speed);
		end
	end

endmodule

// ==== src/cpu_en_fsm.sv ====
// CPU enable FSM owning the active turbo mask, settle period, RAM wait and pause
`timescale 1ns/1ps

module cpu_en_fsm #(
	parameter int SETTLE_STROBES = 3
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cpu_n,
	input  clk_ctrl_pkg::turbo_mask_t turbo_req,
	input  logic                      paused,
	input  logic                      ram_ready,
	output clk_ctrl_pkg::turbo_mask_t turbo,
	output logic                      cpu_en
);
	import clk_ctrl_pkg::*;

	localparam int CNT_W = $clog2(SETTLE_STROBES + 1);

	cpu_state_e state;
	logic [CNT_W-1:0] settle_cnt;
	logic             fast;
	logic             mask_change;

	// 28/56 MHz cannot hide RAM latency
	assign fast        = (turbo[4:2] == 3'b000);
	assign mask_change = (turbo_req != turbo);

	// ==============================
	// State machine, steps on cpu_n only
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= ST_RUN;
			settle_cnt <= '0;
			turbo      <= TURBO_ORIG;
			cpu_en     <= 1'b1;
		end else if (cpu_n) begin
			if (mask_change) begin
				// New speed, hold CPU while the clock settles
				turbo      <= turbo_req;
				cpu_en     <= 1'b0;
				settle_cnt <= CNT_W'(SETTLE_STROBES);
				state      <= ST_SETTLE;
			end else begin
				case (state)
					ST_SETTLE: begin
						if (settle_cnt != '0) begin
							settle_cnt <= settle_cnt - 1'b1;
						end else if (ram_ready) begin
							if (paused) begin
								state <= ST_PAUSED;
							end else begin
								state  <= ST_RUN;
								cpu_en <= 1'b1;
							end
						end
					end

					ST_RUN: begin
						if (paused) begin
							state  <= ST_PAUSED;
							cpu_en <= 1'b0;
						end else if (fast && !ram_ready) begin
							state  <= ST_WAIT_RAM; // Wait state
							cpu_en <= 1'b0;
						end
					end

					ST_WAIT_RAM: begin
						if (ram_ready) begin
							if (paused) begin
								state <= ST_PAUSED;
							end else begin
								state  <= ST_RUN;
								cpu_en <= 1'b1;
							end
						end
					end

					ST_PAUSED: begin
						if (!paused && ram_ready) begin
							state  <= ST_RUN;
							cpu_en <= 1'b1;
						end
					end

					default: begin
						state  <= ST_RUN;
						cpu_en <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

// ==== src/cpu_clock_ctrl.sv ====
// Top level of the CPU clock and speed controller with gated CPU strobes
`timescale 1ns/1ps

module cpu_clock_ctrl #(
	parameter int SETTLE_STROBES = 3
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [4:0]           speed_key,
	input  logic                 pause_key,
	input  logic                 mod_active,
	input  logic                 tape_active,
	input  logic                 fast_tape_en,
	input  logic                 ram_ready,
	output logic                 ce_7mp,
	output logic                 ce_7mn,
	output logic                 ce_cpu_p,
	output logic                 ce_cpu_n,
	output logic                 cpu_en,
	output logic                 paused,
	output clk_ctrl_pkg::speed_e speed
);
	import clk_ctrl_pkg::*;

	turbo_mask_t turbo_req; // Requested by keys or tape
	turbo_mask_t turbo;     // Active mask from the FSM
	logic        cpu_p;
	logic        cpu_n;

	// ==============================
	// Divider
	// ==============================
	ce_divider u_divider (
		.clk_sys (clk_sys),
		.reset   (reset),
		.turbo   (turbo),
		.ce_7mp  (ce_7mp),
		.ce_7mn  (ce_7mn),
		.cpu_p   (cpu_p),
		.cpu_n   (cpu_n)
	);

	speed_request u_speed_req (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.speed_key    (speed_key),
		.pause_key    (pause_key),
		.mod_active   (mod_active),
		.tape_active  (tape_active),
		.fast_tape_en (fast_tape_en),
		.speed        (speed),
		.paused       (paused),
		.turbo_req    (turbo_req)
	);

	cpu_en_fsm #(
		.SETTLE_STROBES (SETTLE_STROBES)
	) u_cpu_en_fsm (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_n     (cpu_n),
		.turbo_req (turbo_req),
		.paused    (paused),
		.ram_ready (ram_ready),
		.turbo     (turbo),
		.cpu_en    (cpu_en)
	);

	// CPU sees strobes only while enabled
	assign ce_cpu_p = cpu_p & cpu_en;
	assign ce_cpu_n = cpu_n & cpu_en;

endmodule

// ==== tb/cpu_clock_ctrl_props.sv ====
// Bound assertions on CPU strobe overlap, 56M alternation, enable timing and the 7 MHz period
`timescale 1ns/1ps

module cpu_clock_ctrl_props (
	input logic                      clk_sys,
	input logic                      reset,
	input logic                      ce_7mp,
	input logic                      ce_cpu_p,
	input logic                      ce_cpu_n,
	input logic                      cpu_p,
	input logic                      cpu_n,
	input logic                      cpu_en,
	input clk_ctrl_pkg::turbo_mask_t turbo
);
	import clk_ctrl_pkg::*;

	int unsigned fail_count = 0; // Failed assertions so far

	// Phases never coincide
	strobe_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n))
		else begin
			fail_count++;
			$error("ce_cpu_p and ce_cpu_n pulsed in the same cycle");
		end

	// Steady 56M mask, p then n on the next cycle
	alt_56m: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_p && turbo == TURBO_56M && $past(turbo) == TURBO_56M) |=> cpu_n)
		else begin
			fail_count++;
			$error("cpu_n did not follow cpu_p at the 56M mask");
		end

	// Enable moves only on a cpu_n strobe, so gating cuts whole CPU periods
	en_on_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_en != $past(cpu_en)) |-> $past(cpu_n))
		else begin
			fail_count++;
			$error("cpu_en changed without a cpu_n strobe");
		end

	period_7m: assert property (@(posedge clk_sys) disable iff (reset)
		ce_7mp |=> !ce_7mp [*15] ##1 ce_7mp)
		else begin
			fail_count++;
			$error("ce_7mp period is not 16 cycles");
		end

endmodule

bind cpu_clock_ctrl cpu_clock_ctrl_props u_props (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.ce_7mp   (ce_7mp),
	.ce_cpu_p (ce_cpu_p),
	.ce_cpu_n (ce_cpu_n),
	.cpu_p    (cpu_p),
	.cpu_n    (cpu_n),
	.cpu_en   (cpu_en),
	.turbo    (turbo)
);

// ==== tb/cpu_clock_ctrl_tb.sv ====
// Trace-driven testbench for the CPU clock controller with pulse counting, checks and watchdog
`timescale 1ns/1ps

module cpu_clock_ctrl_tb;
	import clk_ctrl_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int N_ARGS     = 6; // Numeric fields per trace line

	logic       clk_sys;
	logic       reset;
	logic [4:0] speed_key;
	logic       pause_key;
	logic       mod_active;
	logic       tape_active;
	logic       fast_tape_en;
	logic       ram_ready;
	logic       ce_7mp;
	logic       ce_7mn;
	logic       ce_cpu_p;
	logic       ce_cpu_n;
	logic       cpu_en;
	logic       paused;
	speed_e     speed;

	byte step_cmd[$];
	int  step_arg[$]; // N_ARGS entries per step
	int  limit_cycles;
	bit  trace_loaded;

	cpu_clock_ctrl #(
		.SETTLE_STROBES (3)
	) uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.speed_key    (speed_key),
		.pause_key    (pause_key),
		.mod_active   (mod_active),
		.tape_active  (tape_active),
		.fast_tape_en (fast_tape_en),
		.ram_ready    (ram_ready),
		.ce_7mp       (ce_7mp),
		.ce_7mn       (ce_7mn),
		.ce_cpu_p     (ce_cpu_p),
		.ce_cpu_n     (ce_cpu_n),
		.cpu_en       (cpu_en),
		.paused       (paused),
		.speed        (speed)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==============================
	// Error handling
	// ==============================
	task automatic stop_on_error();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		stop_on_error();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_on_error();
		end
	endtask

	// Bound checker failures end the run too
	always @(negedge clk_sys) begin
		if (uut.u_props.fail_count != 0) abort_run("A bound assertion failed");
	end

	// ==============================
	// Trace loading
	// ==============================
	task automatic load_trace();
		int    fd;
		string line;
		byte   cmd;
		int    a[N_ARGS];
		fd = $fopen("tb/cpu_clock_trace.txt", "r");
		if (fd == 0) abort_run("Could not open the trace file tb/cpu_clock_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0) continue;
			cmd = line.getc(0);
			if (cmd == "#" || cmd == "\n" || cmd == " " || cmd == "\r") continue;
			foreach (a[k]) a[k] = 0;
			void'($sscanf(line, "%c %d %d %d %d %d %d", cmd, a[0], a[1], a[2], a[3], a[4],
				a[5]));
			step_cmd.push_back(cmd);
			foreach (a[k]) step_arg.push_back(a[k]);
		end
		$fclose(fd);
	endtask

	// Worst case length of the whole trace in cycles
	function automatic int trace_cycles();
		int total;
		total = 500;
		foreach (step_cmd[i]) begin
			total += 8; // Idle gap
			case (step_cmd[i])
				"C":     total += step_arg[i * N_ARGS + 1] + 200;
				"D":     total += step_arg[i * N_ARGS];
				"W":     total += 200;
				default: total += 4;
			endcase
		end
		return total;
	endfunction

	// ==============================
	// Step tasks
	// ==============================
	task automatic set_levels(input int m, input int t, input int f, input int r);
		@(posedge clk_sys);
		mod_active   <= m[0];
		tape_active  <= t[0];
		fast_tape_en <= f[0];
		ram_ready    <= r[0];
	endtask

	task automatic press_speed_key(input int idx);
		@(posedge clk_sys);
		speed_key <= 5'b00001 << idx;
		repeat (2) @(posedge clk_sys);
		speed_key <= '0;
	endtask

	task automatic press_pause();
		@(posedge clk_sys);
		pause_key <= 1'b1;
		repeat (2) @(posedge clk_sys);
		pause_key <= 1'b0;
	endtask

	task automatic wait_cpu_en();
		@(negedge clk_sys);
		while (!cpu_en) @(negedge clk_sys);
	endtask

	task automatic count_window(input int sync, input int window, input int exp_cpu,
			input int exp_7m, input int exp_speed, input int exp_paused);
		int n_cpu;
		int n_cpu_n;
		int n_7m;
		int n_7mn;
		n_cpu   = 0;
		n_cpu_n = 0;
		n_7m    = 0;
		n_7mn   = 0;
		if (window % 32 != 0) abort_run("Trace window is not a multiple of 32 cycles");
		if (sync != 0) begin
			wait_cpu_en();
		end else begin
			@(negedge clk_sys);
		end
		check_value("speed", 32'(speed), exp_speed);
		check_value("paused", 32'(paused), exp_paused);
		repeat (window) begin
			@(negedge clk_sys);
			if (ce_cpu_p) n_cpu++;
			if (ce_cpu_n) n_cpu_n++;
			if (ce_7mp) n_7m++;
			if (ce_7mn) n_7mn++;
		end
		// One n strobe per period, same count as p over whole periods
		check_value("ce_cpu_p count", n_cpu, exp_cpu);
		check_value("ce_cpu_n count", n_cpu_n, exp_cpu);
		check_value("ce_7mp count", n_7m, exp_7m);
		check_value("ce_7mn count", n_7mn, exp_7m);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int base;
		int gap;
		clk_sys      = 1'b0;
		reset        = 1'b1;
		speed_key    = '0;
		pause_key    = 1'b0;
		mod_active   = 1'b0;
		tape_active  = 1'b0;
		fast_tape_en = 1'b0;
		ram_ready    = 1'b1;
		void'($urandom(32'h580e5c2c));
		load_trace();
		limit_cycles = trace_cycles();
		trace_loaded = 1'b1;

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		foreach (step_cmd[i]) begin
			base = i * N_ARGS;
			gap  = $urandom_range(0, 7);
			repeat (gap) @(posedge clk_sys);
			case (step_cmd[i])
				"I": set_levels(step_arg[base], step_arg[base + 1], step_arg[base + 2],
					step_arg[base + 3]);
				"K": press_speed_key(step_arg[base]);
				"P": press_pause();
				"D": repeat (step_arg[base]) @(posedge clk_sys);
				"W": wait_cpu_en();
				"C": count_window(step_arg[base], step_arg[base + 1], step_arg[base + 2],
					step_arg[base + 3], step_arg[base + 4], step_arg[base + 5]);
				default: abort_run("Unknown command in the trace file");
			endcase
		end

		if (uut.u_props.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run("A bound assertion failed");
		end
	end

	// Watchdog
	initial begin
		wait (trace_loaded);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("Timeout: the trace did not finish within %0d cycles", limit_cycles);
		stop_on_error();
	end

endmodule

// ==== tb/cpu_clock_trace.txt ====
# Steps, decimal fields: I mod tape fast ram | K key_index | P | D cycles | W
# C sync window exp_ce_cpu_p exp_ce_7mp exp_speed exp_paused
C 1 256 8 16 0 0
K 1
D 40
C 1 256 16 16 1 0
K 2
D 40
C 1 256 32 16 2 0
K 3
D 40
C 1 256 64 16 3 0
K 4
D 40
C 1 256 128 16 4 0
K 0
D 40
C 1 256 8 16 0 0
# Modifier held, key ignored
I 1 0 0 1
K 3
D 40
C 1 256 8 16 0 0
I 0 0 0 1
K 2
D 40
C 1 256 32 16 2 0
# Fast tape load forces 56M
I 0 1 1 1
D 40
C 1 256 128 16 2 0
I 0 1 0 1
D 40
C 1 256 32 16 2 0
I 0 0 0 1
P
D 40
C 0 256 0 16 2 1
P
D 40
C 1 256 32 16 2 0
K 3
D 40
C 1 256 64 16 3 0
# RAM not ready
I 0 0 0 0
D 40
C 0 256 0 16 3 0
I 0 0 0 1
W
K 0
D 40
C 1 256 8 16 0 0
I 0 0 0 0
D 40
C 0 256 8 16 0 0

// ==== flist.f ====
src/clk_ctrl_pkg.sv
src/ce_divider.sv
src/speed_request.sv
src/cpu_en_fsm.sv
src/cpu_clock_ctrl.sv
tb/cpu_clock_ctrl_props.sv
tb/cpu_clock_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_clock_ctrl

sources:
  - files:
      - src/clk_ctrl_pkg.sv
      - src/ce_divider.sv
      - src/speed_request.sv
      - src/cpu_en_fsm.sv
      - src/cpu_clock_ctrl.sv
  - target: test
    files:
      - tb/cpu_clock_ctrl_props.sv
      - tb/cpu_clock_ctrl_tb.sv
